// File: verilog/vehicle_pkg.sv
`default_nettype none

package vehicle_pkg;

    // ====================
    // widths
    // ====================
    localparam int unsigned SPEED_W    = 8;
    localparam int unsigned RPM_W      = 14;
    localparam int unsigned ACCEL_W    = 8;
    localparam int unsigned GEAR_W     = 3;
    localparam int unsigned FUEL_W     = 8;
    localparam int unsigned ODO_W      = 32;
    localparam int unsigned FORCE_W    = 10;
    localparam int unsigned DECEL_W    = 5;
    localparam int unsigned FUEL_ACC_W = 16;

    // driver selector positions
    typedef enum logic [3:0] {
        SEL_P = 4'd3,
        SEL_R = 4'd6,
        SEL_N = 4'd9,
        SEL_D = 4'd12
    } gear_sel_e;

    typedef logic [SPEED_W-1:0] speed_t;
    typedef logic [RPM_W-1:0]   rpm_t;
    typedef logic [ACCEL_W-1:0] accel_t;
    typedef logic [GEAR_W-1:0]  gear_t;

    // ====================
    // engine and pedal
    // ====================
    localparam rpm_t   IDLE_RPM        = 14'd800;
    localparam rpm_t   PARK_RPM_LIMIT  = 14'd4000;
    localparam rpm_t   REDLINE_RPM     = 14'd8000;
    // no more speed gain this close to the redline
    localparam rpm_t   ACCEL_RPM_LIMIT = 14'd7900;
    localparam accel_t ACCEL_DEAD_ZONE = 8'd5;
    localparam accel_t SMOOTH_DECAY    = 8'd8;

    // ====================
    // vehicle physics
    // ====================
    localparam speed_t SPEED_MAX         = 8'd250;
    localparam speed_t REVERSE_SPEED_MAX = 8'd50;
    localparam speed_t AERO_SPEED        = 8'd180;
    localparam speed_t AERO_DRAG         = 8'd100;
    localparam speed_t BASE_RESISTANCE   = 8'd5;
    localparam speed_t ESS_SPEED         = 8'd50;

    // ====================
    // trip data
    // ====================
    // 1 km/h is about 278 mm travelled per second
    localparam logic [ODO_W-1:0]      MM_PER_KMH_SEC = 32'd278;
    localparam logic [ODO_W-1:0]      MM_PER_KM      = 32'd1_000_000;
    localparam logic [FUEL_ACC_W-1:0] FUEL_BASE      = 16'd10;
    localparam logic [FUEL_ACC_W-1:0] FUEL_STEP      = 16'd5000;
    localparam logic [FUEL_W-1:0]     FUEL_FULL      = 8'd100;

endpackage

`default_nettype wire

// File: verilog/accel_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module accel_conditioner (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick_speed,
    input  vehicle_pkg::accel_t adc_accel,
    output vehicle_pkg::accel_t effective_accel,
    output vehicle_pkg::accel_t smooth_accel
);

    // small readings near a released pedal are treated as zero
    assign effective_accel = (adc_accel > vehicle_pkg::ACCEL_DEAD_ZONE) ?
                             adc_accel - vehicle_pkg::ACCEL_DEAD_ZONE : '0;

    // fast attack, slow release so rpm does not collapse when the pedal lifts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            smooth_accel <= '0;
        end else if (tick_speed) begin
            if (effective_accel > smooth_accel) begin
                smooth_accel <= effective_accel;
            end else if (effective_accel < smooth_accel) begin
                if (smooth_accel >= vehicle_pkg::SMOOTH_DECAY) begin
                    smooth_accel <= smooth_accel - vehicle_pkg::SMOOTH_DECAY;
                end else begin
                    // last partial step
                    smooth_accel <= effective_accel;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/speed_dynamics.sv
`timescale 1ns/1ps
`default_nettype none

module speed_dynamics (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick_speed,
    input  logic                   engine_on,
    input  logic                   brake_normal,
    input  logic                   brake_hard,
    input  vehicle_pkg::gear_sel_e gear_sel,
    input  vehicle_pkg::accel_t    effective_accel,
    input  vehicle_pkg::gear_t     gear_num,
    input  vehicle_pkg::rpm_t      rpm,
    output vehicle_pkg::speed_t    speed,
    output logic                   ess_trigger
);

    typedef logic [vehicle_pkg::FORCE_W-1:0] force_t;

    force_t                            power;
    force_t                            resistance;
    vehicle_pkg::speed_t               brake_step;
    logic [vehicle_pkg::DECEL_W-1:0]   decel_cnt;
    logic [vehicle_pkg::DECEL_W-1:0]   decel_limit;
    logic                              in_reverse;

    assign in_reverse = (gear_sel == vehicle_pkg::SEL_R);

    // ====================
    // forces
    // ====================
    always_comb begin
        if (engine_on && gear_sel == vehicle_pkg::SEL_D) begin
            power = force_t'(effective_accel);
        end else if (engine_on && in_reverse) begin
            power = force_t'(effective_accel >> 1);
        end else begin
            power = '0;
        end
    end

    // aero drag kicks in as a step at high speed
    always_comb begin
        resistance = force_t'(speed) + force_t'(vehicle_pkg::BASE_RESISTANCE);
        if (speed >= vehicle_pkg::AERO_SPEED) begin
            resistance = resistance + force_t'(vehicle_pkg::AERO_DRAG);
        end
    end

    // high speed bands skid more, so they lose less per tick
    always_comb begin
        if (speed > 8'd150) begin
            brake_step = brake_hard ? 8'd2 : 8'd1;
        end else if (speed > 8'd80) begin
            brake_step = brake_hard ? 8'd4 : 8'd2;
        end else begin
            brake_step = brake_hard ? 8'd8 : 8'd3;
        end
    end

    // ticks per 1 km/h lost while coasting
    always_comb begin
        case (gear_num)
            3'd1: decel_limit = 5'd1;
            3'd2: decel_limit = 5'd3;
            3'd3: decel_limit = 5'd6;
            3'd4: decel_limit = 5'd10;
            3'd5: decel_limit = (speed >= 8'd120) ? 5'd8 : 5'd15;
            3'd6: begin
                if (speed >= 8'd170) begin
                    decel_limit = 5'd2;
                end else if (speed >= 8'd140) begin
                    decel_limit = 5'd5;
                end else begin
                    decel_limit = 5'd20;
                end
            end
            default: decel_limit = '0;
        endcase
    end

    // ====================
    // speed state
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed       <= '0;
            ess_trigger <= 1'b0;
            decel_cnt   <= '0;
        end else if (tick_speed) begin
            if (brake_hard || brake_normal) begin
                speed <= (speed > brake_step) ? speed - brake_step : '0;
                // emergency stop signal only for a hard stop from speed
                ess_trigger <= brake_hard && (speed > vehicle_pkg::ESS_SPEED);
            end else begin
                ess_trigger <= 1'b0;
                if (power > resistance) begin
                    decel_cnt <= '0;
                    if (!(in_reverse && speed >= vehicle_pkg::REVERSE_SPEED_MAX) &&
                        speed < vehicle_pkg::SPEED_MAX &&
                        rpm < vehicle_pkg::ACCEL_RPM_LIMIT) begin
                        speed <= speed + 8'd1;
                    end
                end else if (power < resistance) begin
                    if (speed == '0) begin
                        decel_cnt <= '0;
                    end else if (decel_cnt >= decel_limit) begin
                        speed     <= speed - 8'd1;
                        decel_cnt <= '0;
                    end else begin
                        decel_cnt <= decel_cnt + 5'd1;
                    end
                end else begin
                    // balanced, hold speed
                    decel_cnt <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/gear_selector.sv
`timescale 1ns/1ps
`default_nettype none

module gear_selector (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick_speed,
    input  logic                   brake_normal,
    input  logic                   brake_hard,
    input  vehicle_pkg::gear_sel_e gear_sel,
    input  vehicle_pkg::accel_t    effective_accel,
    input  vehicle_pkg::speed_t    speed,
    output vehicle_pkg::gear_t     gear_num
);

    vehicle_pkg::gear_t coast_gear;

    // pedal released: gear follows speed directly
    always_comb begin
        if (speed < 8'd20) begin
            coast_gear = 3'd1;
        end else if (speed < 8'd50) begin
            coast_gear = 3'd2;
        end else if (speed < 8'd75) begin
            coast_gear = 3'd3;
        end else if (speed < 8'd100) begin
            coast_gear = 3'd4;
        end else if (speed < 8'd125) begin
            coast_gear = 3'd5;
        end else begin
            coast_gear = 3'd6;
        end
    end

    // gear is held while braking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gear_num <= 3'd1;
        end else if (tick_speed && !brake_normal && !brake_hard) begin
            if (gear_sel != vehicle_pkg::SEL_D) begin
                gear_num <= 3'd1;
            end else if (effective_accel == '0) begin
                gear_num <= coast_gear;
            end else begin
                // pedal down, upshift and downshift points differ
                case (gear_num)
                    3'd1: if (speed >= 8'd27) gear_num <= 3'd2;
                    3'd2: begin
                        if (speed < 8'd21) gear_num <= 3'd1;
                        else if (speed >= 8'd56) gear_num <= 3'd3;
                    end
                    3'd3: begin
                        if (speed < 8'd51) gear_num <= 3'd2;
                        else if (speed >= 8'd86) gear_num <= 3'd4;
                    end
                    3'd4: begin
                        if (speed < 8'd77) gear_num <= 3'd3;
                        else if (speed >= 8'd117) gear_num <= 3'd5;
                    end
                    3'd5: begin
                        if (speed < 8'd101) gear_num <= 3'd4;
                        else if (speed >= 8'd146) gear_num <= 3'd6;
                    end
                    3'd6: if (speed < 8'd128) gear_num <= 3'd5;
                    default: gear_num <= 3'd1;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rpm_calc.sv
`timescale 1ns/1ps
`default_nettype none

module rpm_calc (
    input  logic                   engine_on,
    input  vehicle_pkg::gear_sel_e gear_sel,
    input  vehicle_pkg::speed_t    speed,
    input  vehicle_pkg::gear_t     gear_num,
    input  vehicle_pkg::accel_t    smooth_accel,
    input  vehicle_pkg::accel_t    adc_accel,
    output vehicle_pkg::rpm_t      rpm
);

    // wide enough for 250 km/h in first gear
    logic [15:0] speed_wide;
    logic [15:0] park_rpm;
    logic [15:0] drive_base;
    logic [15:0] drive_rpm;

    assign speed_wide = 16'(speed);

    // free revving uses the raw pedal, no dead zone
    assign park_rpm = 16'(vehicle_pkg::IDLE_RPM) + 16'(adc_accel) * 16'd20;

    // rpm per km/h for each gear
    always_comb begin
        case (gear_num)
            3'd1: drive_base = speed_wide * 16'd100;
            3'd2: drive_base = speed_wide * 16'd60;
            3'd3: drive_base = speed_wide * 16'd40;
            3'd4: drive_base = speed_wide * 16'd30;
            3'd5: drive_base = speed_wide * 16'd24;
            3'd6: drive_base = speed_wide * 16'd18;
            default: drive_base = 16'(vehicle_pkg::IDLE_RPM);
        endcase
    end

    // converter slip adds load on top of the road speed
    assign drive_rpm = drive_base + 16'(smooth_accel) * 16'd2;

    always_comb begin
        if (!engine_on) begin
            rpm = '0;
        end else if (gear_sel == vehicle_pkg::SEL_P || gear_sel == vehicle_pkg::SEL_N) begin
            rpm = (park_rpm > 16'(vehicle_pkg::PARK_RPM_LIMIT)) ?
                  vehicle_pkg::PARK_RPM_LIMIT : vehicle_pkg::rpm_t'(park_rpm);
        end else begin
            rpm = (drive_rpm > 16'(vehicle_pkg::REDLINE_RPM)) ?
                  vehicle_pkg::REDLINE_RPM : vehicle_pkg::rpm_t'(drive_rpm);
        end
    end

endmodule

`default_nettype wire

// File: verilog/trip_meter.sv
`timescale 1ns/1ps
`default_nettype none

module trip_meter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              tick_1sec,
    input  logic                              engine_on,
    input  vehicle_pkg::speed_t               speed,
    input  vehicle_pkg::rpm_t                 rpm,
    input  vehicle_pkg::accel_t               effective_accel,
    output logic [vehicle_pkg::FUEL_W-1:0]    fuel,
    output logic [vehicle_pkg::ODO_W-1:0]     odometer_km
);

    logic [vehicle_pkg::ODO_W-1:0]      dist_acc;
    logic [vehicle_pkg::ODO_W-1:0]      dist_step;
    logic [vehicle_pkg::FUEL_ACC_W-1:0] fuel_acc;
    logic [vehicle_pkg::FUEL_ACC_W-1:0] fuel_burn;

    // ====================
    // odometer
    // ====================
    assign dist_step = 32'(speed) * vehicle_pkg::MM_PER_KMH_SEC;

    // distance accumulates in mm, a full km rolls over into the odometer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dist_acc    <= '0;
            odometer_km <= '0;
        end else if (tick_1sec && engine_on && speed != '0) begin
            if (dist_acc >= vehicle_pkg::MM_PER_KM) begin
                dist_acc    <= dist_acc - vehicle_pkg::MM_PER_KM;
                odometer_km <= odometer_km + 32'd1;
            end else begin
                dist_acc <= dist_acc + dist_step;
            end
        end
    end

    // ====================
    // fuel
    // ====================
    // burn per second grows with engine speed and load
    assign fuel_burn = vehicle_pkg::FUEL_BASE + 16'(rpm / 14'd100) + 16'(effective_accel);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fuel_acc <= '0;
            fuel     <= vehicle_pkg::FUEL_FULL;
        end else if (tick_1sec && engine_on) begin
            if (fuel_acc >= vehicle_pkg::FUEL_STEP) begin
                fuel_acc <= '0;
                if (fuel != '0) begin
                    fuel <= fuel - 8'd1;
                end
            end else begin
                fuel_acc <= fuel_acc + fuel_burn;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/vehicle_top.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              engine_on,
    input  logic                              tick_1sec,
    input  logic                              tick_speed,
    input  vehicle_pkg::gear_sel_e            gear_sel,
    input  vehicle_pkg::accel_t               adc_accel,
    input  logic                              brake_normal,
    input  logic                              brake_hard,
    output vehicle_pkg::speed_t               speed,
    output vehicle_pkg::rpm_t                 rpm,
    output logic [vehicle_pkg::FUEL_W-1:0]    fuel,
    output logic [vehicle_pkg::ODO_W-1:0]     odometer_km,
    output logic                              ess_trigger,
    output vehicle_pkg::gear_t                gear_num
);

    vehicle_pkg::accel_t effective_accel;
    vehicle_pkg::accel_t smooth_accel;

    // pedal front end
    accel_conditioner u_accel (
        .clk             (clk),
        .rst             (rst),
        .tick_speed      (tick_speed),
        .adc_accel       (adc_accel),
        .effective_accel (effective_accel),
        .smooth_accel    (smooth_accel)
    );

    speed_dynamics u_speed (
        .clk             (clk),
        .rst             (rst),
        .tick_speed      (tick_speed),
        .engine_on       (engine_on),
        .brake_normal    (brake_normal),
        .brake_hard      (brake_hard),
        .gear_sel        (gear_sel),
        .effective_accel (effective_accel),
        .gear_num        (gear_num),
        .rpm             (rpm),
        .speed           (speed),
        .ess_trigger     (ess_trigger)
    );

    // shifts on the same tick as speed, so it sees the old speed
    gear_selector u_gear (
        .clk             (clk),
        .rst             (rst),
        .tick_speed      (tick_speed),
        .brake_normal    (brake_normal),
        .brake_hard      (brake_hard),
        .gear_sel        (gear_sel),
        .effective_accel (effective_accel),
        .speed           (speed),
        .gear_num        (gear_num)
    );

    rpm_calc u_rpm (
        .engine_on    (engine_on),
        .gear_sel     (gear_sel),
        .speed        (speed),
        .gear_num     (gear_num),
        .smooth_accel (smooth_accel),
        .adc_accel    (adc_accel),
        .rpm          (rpm)
    );

    trip_meter u_trip (
        .clk             (clk),
        .rst             (rst),
        .tick_1sec       (tick_1sec),
        .engine_on       (engine_on),
        .speed           (speed),
        .rpm             (rpm),
        .effective_accel (effective_accel),
        .fuel            (fuel),
        .odometer_km     (odometer_km)
    );

endmodule

`default_nettype wire

// File: verification/vehicle_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_asserts (
    input logic               clk,
    input logic               rst,
    input logic               engine_on,
    input logic               tick_speed,
    input logic               brake_hard,
    input logic               ess_trigger,
    input vehicle_pkg::rpm_t  rpm,
    input vehicle_pkg::gear_t gear_num
);

    // number of assertion failures so far
    int fail_count = 0;

    // ess is only raised by a speed tick taken with the hard brake held
    ess_needs_hard_brake: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ess_trigger) |-> $past(tick_speed && brake_hard)
    ) else begin
        $error("ess_trigger rose without a hard brake tick");
        fail_count++;
    end

    rpm_below_redline: assert property (
        @(posedge clk) disable iff (rst)
        rpm <= vehicle_pkg::REDLINE_RPM
    ) else begin
        $error("rpm above the redline");
        fail_count++;
    end

    gear_in_range: assert property (
        @(posedge clk) disable iff (rst)
        gear_num >= 3'd1 && gear_num <= 3'd6
    ) else begin
        $error("gear_num outside 1 to 6");
        fail_count++;
    end

    // a stopped engine does not turn
    rpm_zero_when_off: assert property (
        @(posedge clk) disable iff (rst)
        !engine_on |-> rpm == '0
    ) else begin
        $error("rpm nonzero with the engine off");
        fail_count++;
    end

endmodule

bind vehicle_top vehicle_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .engine_on   (engine_on),
    .tick_speed  (tick_speed),
    .brake_hard  (brake_hard),
    .ess_trigger (ess_trigger),
    .rpm         (rpm),
    .gear_num    (gear_num)
);

`default_nettype wire

// File: verification/vehicle_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_tb;

    // one line of the stimulus file
    typedef struct packed {
        int test_id;
        int engine_on;
        int gear_sel;
        int adc_accel;
        int brake_normal;
        int brake_hard;
        int speed_ticks;
        int sec_ticks;
        int exp_speed;
        int exp_gear;
        int exp_rpm;
        int exp_ess;
        int exp_fuel;
        int exp_odometer;
    } step_t;

    logic                             clk;
    logic                             rst;
    logic                             engine_on;
    logic                             tick_1sec;
    logic                             tick_speed;
    vehicle_pkg::gear_sel_e           gear_sel;
    vehicle_pkg::accel_t              adc_accel;
    logic                             brake_normal;
    logic                             brake_hard;
    vehicle_pkg::speed_t              speed;
    vehicle_pkg::rpm_t                rpm;
    logic [vehicle_pkg::FUEL_W-1:0]   fuel;
    logic [vehicle_pkg::ODO_W-1:0]    odometer_km;
    logic                             ess_trigger;
    vehicle_pkg::gear_t               gear_num;

    step_t steps[$];
    int    error_count;
    int    check_count;
    int    watchdog_cycles;
    logic  load_done;

    vehicle_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .engine_on    (engine_on),
        .tick_1sec    (tick_1sec),
        .tick_speed   (tick_speed),
        .gear_sel     (gear_sel),
        .adc_accel    (adc_accel),
        .brake_normal (brake_normal),
        .brake_hard   (brake_hard),
        .speed        (speed),
        .rpm          (rpm),
        .fuel         (fuel),
        .odometer_km  (odometer_km),
        .ess_trigger  (ess_trigger),
        .gear_num     (gear_num)
    );

    always #10 clk = ~clk;

    // ====================
    // helpers
    // ====================
    task automatic load_steps();
        int    fd;
        int    n;
        int    v [14];
        string line;
        step_t row;
        fd = $fopen("verification/vehicle_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verification/vehicle_input.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                            v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
                // comment and blank lines yield no fields
                if (n == 14) begin
                    row = {v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                           v[7], v[8], v[9], v[10], v[11], v[12], v[13]};
                    steps.push_back(row);
                end
            end
            $fclose(fd);
        end
    endtask

    // one strobe cycle, then three quiet cycles
    task automatic send_ticks(input logic speed_strobe, input int count);
        repeat (count) begin
            if (speed_strobe) begin
                tick_speed = 1'b1;
            end else begin
                tick_1sec = 1'b1;
            end
            @(negedge clk);
            tick_speed = 1'b0;
            tick_1sec  = 1'b0;
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic check_value(input int test_id, input string field,
                               input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("Fail at %0d ns: test %0d %s is %0d, expected %0d",
                     $time, test_id, field, got, expected);
        end
    endtask

    task automatic run_step(input step_t step);
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        engine_on    = step.engine_on[0];
        gear_sel     = vehicle_pkg::gear_sel_e'(step.gear_sel[3:0]);
        adc_accel    = step.adc_accel[7:0];
        brake_normal = step.brake_normal[0];
        brake_hard   = step.brake_hard[0];
        send_ticks(1'b1, step.speed_ticks);
        send_ticks(1'b0, step.sec_ticks);
        @(negedge clk);
        check_value(step.test_id, "speed", int'(speed), step.exp_speed);
        check_value(step.test_id, "gear_num", int'(gear_num), step.exp_gear);
        check_value(step.test_id, "rpm", int'(rpm), step.exp_rpm);
        check_value(step.test_id, "ess_trigger", int'(ess_trigger), step.exp_ess);
        check_value(step.test_id, "fuel", int'(fuel), step.exp_fuel);
        check_value(step.test_id, "odometer_km", int'(odometer_km), step.exp_odometer);
        $display("test %0d done, %0d mismatches", step.test_id, error_count - errors_before);
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        engine_on       = 1'b0;
        tick_1sec       = 1'b0;
        tick_speed      = 1'b0;
        gear_sel        = vehicle_pkg::SEL_P;
        adc_accel       = '0;
        brake_normal    = 1'b0;
        brake_hard      = 1'b0;
        error_count     = 0;
        check_count     = 0;
        watchdog_cycles = 1000;
        load_done       = 1'b0;
        load_steps();
        foreach (steps[i]) begin
            watchdog_cycles += 4 * (steps[i].speed_ticks + steps[i].sec_ticks);
        end
        load_done = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        // bound assertion failures count as errors too
        error_count += u_dut.u_asserts.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors",
                 steps.size(), check_count, error_count);
        if (error_count == 0 && steps.size() > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the tick counts in the stimulus file
    initial begin
        wait (load_done);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run was still busy after %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vehicle_input.txt
# test engine_on gear_sel adc brake_normal brake_hard speed_ticks sec_ticks
#      then expected speed gear_num rpm ess_trigger fuel odometer_km
1   0  3    0  0  0    0    0    0  1     0  0  100  0
2   1  3  100  0  0    2    0    0  1  2800  0  100  0
3   1  3  200  0  0    2    0    0  1  4000  0  100  0
4   1 12  105  0  0   30    0   30  2  2000  0  100  0
5   1 12  105  0  0  100    0   95  4  3050  0  100  0
6   1 12    0  0  1    3    0   83  4  2642  1  100  0
7   1 12    0  0  1    3    0   63  4  1994  1  100  0
8   1 12    0  1  0    3    0   54  4  1676  0  100  0
9   1 12    0  0  1    2    0   38  4  1164  0  100  0
10  1 12    0  0  0    0  100   38  4  1164  0  100  1
11  1 12    0  0  0    0  150   38  4  1164  0   99  2
12  0 12    0  0  0    0   10   38  4     0  0   99  2
13  1  9    0  0  0    4    0   36  1   800  0   99  2
14  1 12    0  0  0    4    0   35  2  2100  0   99  2

// File: project.f
verilog/vehicle_pkg.sv
verilog/accel_conditioner.sv
verilog/speed_dynamics.sv
verilog/gear_selector.sv
verilog/rpm_calc.sv
verilog/trip_meter.sv
verilog/vehicle_top.sv
verification/vehicle_asserts.sv
verification/vehicle_tb.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := vehicle_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
